/* Bender.yml */
package:
  name: stepper_svm

# The cosine table cos_quarter.mem is read at elaboration.
# Run tools from the project root.

sources:
  # Package first, then RTL leaves before the top level
  - files:
      - source/svm_pkg.sv
      - source/microstep_sequencer.sv
      - source/cos_lut.sv
      - source/space_vector_modulator.sv
      - source/pwm_delayed.sv
      - source/stepper_svm_top.sv

  # Testbench only in simulation
  - target: simulation
    files:
      - dv/tb_stepper_svm.sv

/* cos_quarter.mem */
// One hex byte per line: 127.5 * (1 + cos((k + 0.5) * pi / 128)) for k = 0 to 63
ff
ff
ff
ff
fe
fe
fd
fd
fc
fc
fb
fa
f9
f8
f7
f6
f5
f3
f2
f1
ef
ee
ec
ea
e9
e7
e5
e3
e1
df
dd
db
d9
d6
d4
d2
cf
cd
ca
c8
c5
c2
c0
bd
ba
b7
b5
b2
af
ac
a9
a6
a3
a0
9d
9a
97
94
91
8e
8a
87
84
81

/* dv/tb_stepper_svm.sv */
// Run from the project root so the cosine table is found; checks assume 8 microstep and 4 current bits
`timescale 1ns/1ps

module tb_stepper_svm;

  import svm_pkg::*;

  localparam int microstep_bits = 8;
  localparam int current_bits   = 4;
  localparam int pwm_w          = microstep_bits + current_bits;
  localparam int period         = 1 << pwm_w;      // Cycles per PWM period
  localparam int turn           = 1 << phase_w;    // Angle steps per electrical turn
  localparam int n_rows         = 15;
  localparam int max_steps      = 256;             // Upper bound on steps in any row
  localparam int reset_cycles   = 16;
  localparam int sync_bound     = period + 8;      // Longest legal wait for pwm_sync
  // Three periods per row plus reset and the idle period, with slack for step bursts
  localparam int cycle_limit    = (n_rows * 3 + 3) * period + n_rows * (max_steps + 16);

  logic       clk;
  logic       resetn;
  logic       step;
  logic       dir;
  logic       coil_en;
  logic [7:0] current;
  logic       vref_a;
  logic       vref_b;
  logic       pwm_sync;

  // Model copy of the quarter table
  logic [7:0] quarter_q [0:quarter_ct-1];

  // Stimulus table with one entry per row
  string row_name  [n_rows];
  int    row_steps [n_rows];
  bit    row_dir   [n_rows];
  bit    row_en    [n_rows];
  int    row_cur   [n_rows];
  int    row_fill;             // Next free row

  int     mismatches;
  int     other_errors;
  int     cycles;
  int     since_sync;          // Cycles since the last pwm_sync
  bit     sync_seen;
  integer seed;

  stepper_svm_top #(
    .microstep_bits(microstep_bits),
    .current_bits  (current_bits)
  ) u_stepper_svm_top (
    .clk, .resetn, .step, .dir, .coil_en, .current,
    .vref_a, .vref_b, .pwm_sync
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // Full-circle table value by quadrant folding
  function automatic int table_value(input int idx);
    int quad;
    int k;
    quad = (idx / quarter_ct) % 4;
    k    = idx % quarter_ct;
    case (quad)
      0:       return quarter_q[k];
      1:       return 255 - quarter_q[quarter_ct - 1 - k];  // Falling below midline
      2:       return 255 - quarter_q[k];
      default: return quarter_q[quarter_ct - 1 - k];        // Rising back to the top
    endcase
  endfunction

  // Expected high times and start offsets for one angle and current command
  task automatic predict(input int angle, input int cur, input bit en,
                         output int val_a, output int val_b,
                         output int dly_a, output int dly_b);
    int amp_a;
    int amp_b;
    int cur_t;
    amp_a = table_value((angle + quarter_ct) % turn) >> (8 - microstep_bits);  // Cosine
    amp_b = table_value(angle) >> (8 - microstep_bits);                        // Sine
    cur_t = en ? (cur >> (8 - current_bits)) : 0;  // Disabled coils carry nothing
    val_a = amp_a * cur_t;
    val_b = amp_b * cur_t;
    dly_a = 0;
    dly_b = 0;
    if (val_a >= val_b) begin
      dly_b = (val_a - val_b) / 2;
    end else begin
      dly_a = (val_b - val_a) / 2;
    end
  endtask

  task automatic add_row(input string name, input int steps, input bit fwd,
                         input bit en, input int cur);
    row_name[row_fill]  = name;
    row_steps[row_fill] = steps;
    row_dir[row_fill]   = fwd;
    row_en[row_fill]    = en;
    row_cur[row_fill]   = cur;
    row_fill++;
  endtask

  task automatic fill_table();
    integer rnd;
    row_fill = 0;
    add_row("zero_angle_full", 0,   1'b1, 1'b1, 255);  // Angle 0
    add_row("fwd_16",          16,  1'b1, 1'b1, 255);
    add_row("fwd_quad1",       64,  1'b1, 1'b1, 255);  // Angle 80
    add_row("fwd_quad2",       64,  1'b1, 1'b1, 255);  // Angle 144
    add_row("fwd_quad3",       64,  1'b1, 1'b1, 255);  // Angle 208
    add_row("wrap_fwd",        60,  1'b1, 1'b1, 255);  // Through 255 to 12
    add_row("wrap_back",       20,  1'b0, 1'b1, 255);  // Back through 0 to 248
    add_row("back_quad2",      100, 1'b0, 1'b1, 255);  // Angle 148
    add_row("half_current",    0,   1'b1, 1'b1, 128);
    add_row("low_current",     0,   1'b1, 1'b1, 8'h30);
    add_row("coils_off",       0,   1'b1, 1'b0, 255);
    add_row("coils_on",        0,   1'b1, 1'b1, 255);  // Same angle as back_quad2
    for (int r = 0; r < 3; r++) begin
      rnd = $random(seed);
      add_row($sformatf("random_%0d", r), (rnd & 8'hff) + 1, rnd[8], 1'b1, (rnd >> 16) & 8'hff);
    end
  endtask

  // Drive one row; step is held high for one cycle per step
  task automatic apply_row(input int i);
    @(posedge clk);
    dir     <= row_dir[i];
    coil_en <= row_en[i];
    current <= 8'(row_cur[i]);
    repeat (row_steps[i]) begin
      @(posedge clk);
      step <= 1'b1;
    end
    @(posedge clk);
    step <= 1'b0;
  endtask

  // Returns at the falling edge where pwm_sync is high; busy counts vref high cycles meanwhile
  task automatic wait_sync(input string name, output int busy);
    int n;
    n    = 0;
    busy = 0;
    @(negedge clk);
    while (!pwm_sync && n < sync_bound) begin
      if (vref_a || vref_b) busy++;
      @(negedge clk);
      n++;
    end
    if (!pwm_sync) begin
      other_errors++;
      $display("ERROR %s: no pwm_sync within %0d cycles", name, sync_bound);
    end
  endtask

  // Offsets are counted from the pwm_sync cycle; -1 means no high cycle seen
  task automatic measure_period(output int hi_a, output int hi_b,
                                output int first_a, output int first_b);
    hi_a    = 0;
    hi_b    = 0;
    first_a = -1;
    first_b = -1;
    for (int c = 0; c < period; c++) begin
      if (c > 0) @(negedge clk);
      if (vref_a) begin
        hi_a++;
        if (first_a < 0) first_a = c;
      end
      if (vref_b) begin
        hi_b++;
        if (first_b < 0) first_b = c;
      end
    end
  endtask

  task automatic check_row(input string name, input int exp_a, input int exp_b,
                           input int exp_fa, input int exp_fb, input int hi_a,
                           input int hi_b, input int first_a, input int first_b);
    if (hi_a != exp_a) begin
      mismatches++;
      $display("MISMATCH %s vref_a high count expected %0d actual %0d", name, exp_a, hi_a);
    end
    if (hi_b != exp_b) begin
      mismatches++;
      $display("MISMATCH %s vref_b high count expected %0d actual %0d", name, exp_b, hi_b);
    end
    if (first_a != exp_fa) begin
      mismatches++;
      $display("MISMATCH %s vref_a start offset expected %0d actual %0d", name, exp_fa, first_a);
    end
    if (first_b != exp_fb) begin
      mismatches++;
      $display("MISMATCH %s vref_b start offset expected %0d actual %0d", name, exp_fb, first_b);
    end
  endtask

  task automatic print_counts();
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
  endtask

  // Sync spacing watch over the whole test
  always @(negedge clk) begin
    if (resetn) begin
      since_sync = 0;
      sync_seen  = 1'b0;
    end else begin
      since_sync++;
      if (pwm_sync) begin
        if (sync_seen && since_sync != period) begin
          mismatches++;
          $display("MISMATCH sync_interval expected %0d actual %0d", period, since_sync);
        end
        sync_seen  = 1'b1;
        since_sync = 0;
      end
    end
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    other_errors++;
    $display("ERROR timeout: run did not finish within %0d cycles", cycle_limit);
    print_counts();
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int angle;
    int step_size;
    int busy;
    int ev_a;
    int ev_b;
    int ed_a;
    int ed_b;
    int hi_a;
    int hi_b;
    int first_a;
    int first_b;
    resetn       = 1'b1;  // Reset asserted from time zero
    step         = 1'b0;
    dir          = 1'b0;
    coil_en      = 1'b0;
    current      = 8'd0;
    mismatches   = 0;
    other_errors = 0;
    seed         = 58;
    $readmemh(cos_file, quarter_q);
    fill_table();

    repeat (reset_cycles) @(posedge clk);
    resetn <= 1'b0;

    // Nothing commanded yet, so both outputs stay low
    wait_sync("reset", busy);
    if (busy != 0) begin
      other_errors++;
      $display("ERROR reset: vref high for %0d cycles before the first pwm_sync", busy);
    end
    measure_period(hi_a, hi_b, first_a, first_b);
    check_row("idle", 0, 0, -1, -1, hi_a, hi_b, first_a, first_b);

    angle = 0;
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
      step_size = row_steps[i] * (1 << (phase_w - microstep_bits));
      if (row_dir[i]) begin
        angle = (angle + step_size) % turn;
      end else begin
        angle = ((angle - step_size) % turn + turn) % turn;  // Wraps below zero
      end
      predict(angle, row_cur[i], row_en[i], ev_a, ev_b, ed_a, ed_b);
      wait_sync(row_name[i], busy);  // Modulator latches the new values
      wait_sync(row_name[i], busy);  // PWM runs them from here
      measure_period(hi_a, hi_b, first_a, first_b);
      $display("Row %0d %s: angle %0d, expected highs %0d and %0d", i, row_name[i],
               angle, ev_a, ev_b);
      check_row(row_name[i], ev_a, ev_b, (ev_a == 0) ? -1 : ed_a, (ev_b == 0) ? -1 : ed_b,
                hi_a, hi_b, first_a, first_b);
    end

    print_counts();
    if (mismatches == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
source/svm_pkg.sv
source/microstep_sequencer.sv
source/cos_lut.sv
source/space_vector_modulator.sv
source/pwm_delayed.sv
source/stepper_svm_top.sv
dv/tb_stepper_svm.sv

/* source/cos_lut.sv */
// Table contents come from cos_file at elaboration; both ports have one cycle of read latency
`timescale 1ns/1ps

module cos_lut (
  input  logic                       clk,
  input  logic [svm_pkg::phase_w-1:0] idx_a,  // Angle for port A
  input  logic [svm_pkg::phase_w-1:0] idx_b,  // Angle for port B
  output logic [svm_pkg::amp_w-1:0]   amp_a,  // Table value for idx_a, one cycle later
  output logic [svm_pkg::amp_w-1:0]   amp_b   // Table value for idx_b, one cycle later
);

  import svm_pkg::*;

  localparam int addr_w = $clog2(quarter_ct);  // Offset within a quadrant
  localparam int n_port = 2;

  // First quadrant of the offset cosine only
  logic [amp_w-1:0] quarter_rom [0:quarter_ct-1];

  initial begin
    $readmemh(cos_file, quarter_rom);
  end

  // Ports gathered so one block serves both
  logic [phase_w-1:0] idx [n_port];
  logic [amp_w-1:0]   amp [n_port];

  assign idx[0] = idx_a;
  assign idx[1] = idx_b;
  assign amp_a  = amp[0];
  assign amp_b  = amp[1];

  for (genvar p = 0; p < n_port; p++) begin : g_port
    logic [quad_bits-1:0] quad;    // Quadrant of the requested angle
    logic [addr_w-1:0]    k;       // Position inside the quadrant
    logic [addr_w-1:0]    addr;    // Folded ROM address
    logic                 mirror;  // Quadrants 1 and 2 sit below the midline
    logic [amp_w-1:0]     rom_q;   // Registered ROM word
    logic                 mirror_q;

    assign quad = idx[p][phase_w-1 -: quad_bits];
    assign k    = idx[p][addr_w-1:0];

    // Odd quadrants run the table backwards, 63 minus k
    assign addr   = quad[0] ? ~k : k;
    assign mirror = quad[0] ^ quad[1];

    // Registered read, maps onto block RAM
    always_ff @(posedge clk) begin
      rom_q    <= quarter_rom[addr];
      mirror_q <= mirror;  // Travels alongside the data
    end

    // 255 minus the entry for the lower half of the wave
    assign amp[p] = mirror_q ? amp_w'(amp_max) - rom_q : rom_q;
  end

endmodule

/* source/microstep_sequencer.sv */
// Step is a one-cycle strobe; resetn is synchronous and active high; the angle wraps modulo 256
`timescale 1ns/1ps

module microstep_sequencer #(
  parameter int microstep_bits = 8  // 1 to 8, coarser settings take bigger angle steps
) (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       step,          // One microstep per strobe
  input  logic                       dir,           // 1 moves the angle up
  input  logic                       coil_en,       // Low de-energizes both coils
  input  logic [7:0]                 current,       // Requested amplitude level
  output logic [svm_pkg::phase_w-1:0] phase_ct,     // Electrical angle
  output logic [7:0]                 coil_current   // Current after enable gating
);

  import svm_pkg::*;

  // Angle increment per microstep
  // With 8 microstep bits every step moves the angle by one table entry
  localparam logic [phase_w-1:0] step_inc = phase_w'(1 << (phase_w - microstep_bits));

  logic [phase_w-1:0] phase_next;  // Angle after a pending step

  // Wraps naturally through 255 to 0 and back
  always_comb begin
    phase_next = phase_ct;
    if (step) begin
      if (dir) begin
        phase_next = phase_ct + step_inc;  // Forward
      end else begin
        phase_next = phase_ct - step_inc;  // Reverse
      end
    end
  end

  // Angle register
  // Position is kept even while the coils are off
  always_ff @(posedge clk) begin
    if (resetn) begin
      phase_ct <= '0;
    end else begin
      phase_ct <= phase_next;
    end
  end

  // Current command register, forced to zero when disabled
  always_ff @(posedge clk) begin
    if (resetn) begin
      coil_current <= '0;
    end else if (coil_en) begin
      coil_current <= current;
    end else begin
      coil_current <= 8'd0;  // Coils off, angle untouched
    end
  end

endmodule

/* source/pwm_delayed.sv */
// Period is 2**bits cycles; val and delay are sampled once per period at the counter wrap
`timescale 1ns/1ps

module pwm_delayed #(
  parameter int bits = 12  // Counter width
) (
  input  logic            clk,
  input  logic            resetn,
  input  logic [bits-1:0] val,          // High time in cycles
  input  logic [bits-1:0] delay,        // Counter value where the pulse begins
  output logic            pwm,
  output logic            period_start  // High while the counter is zero
);

  logic [bits-1:0] cnt;
  logic [bits-1:0] cnt_next;
  logic            wrap;        // Last cycle of the period
  logic [bits-1:0] val_q;       // Values in use for the current period
  logic [bits-1:0] delay_q;
  logic [bits-1:0] val_next;
  logic [bits-1:0] delay_next;

  assign cnt_next = cnt + 1'b1;
  assign wrap     = &cnt;

  // Fresh values only at the period boundary, never mid-pulse
  assign val_next   = wrap ? val : val_q;
  assign delay_next = wrap ? delay : delay_q;

  always_ff @(posedge clk) begin
    if (resetn) begin
      cnt          <= '0;
      val_q        <= '0;
      delay_q      <= '0;
      pwm          <= 1'b0;
      period_start <= 1'b0;  // Stays low until the first wrap
    end else begin
      cnt          <= cnt_next;
      val_q        <= val_next;
      delay_q      <= delay_next;
      period_start <= wrap;
      // Lookahead so the registered output lines up with cnt
      // Subtraction avoids overflow of delay plus val
      pwm <= (cnt_next >= delay_next) && ((cnt_next - delay_next) < val_next);
    end
  end

endmodule

/* source/space_vector_modulator.sv */
// Values change only at period_start; microstep_bits and current_bits must each be 1 to 8
`timescale 1ns/1ps

module space_vector_modulator #(
  parameter int microstep_bits = 8,  // Amplitude bits kept from the table
  parameter int current_bits   = 4,  // Current bits kept from the command
  localparam int pwm_w = microstep_bits + current_bits
) (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic [svm_pkg::phase_w-1:0] phase_ct,      // Electrical angle
  input  logic [7:0]                  coil_current,  // Gated current command
  input  logic                        period_start,  // Latch strobe from the PWM counter
  output logic [svm_pkg::phase_w-1:0] idx_a,         // Cosine index
  output logic [svm_pkg::phase_w-1:0] idx_b,         // Sine index
  input  logic [svm_pkg::amp_w-1:0]   amp_a,
  input  logic [svm_pkg::amp_w-1:0]   amp_b,
  output logic [pwm_w-1:0]            val_a,         // High time, phase A
  output logic [pwm_w-1:0]            val_b,         // High time, phase B
  output logic [pwm_w-1:0]            delay_a,       // Pulse start, phase A
  output logic [pwm_w-1:0]            delay_b        // Pulse start, phase B
);

  import svm_pkg::*;

  logic [microstep_bits-1:0] amp_a_t;  // Truncated amplitudes
  logic [microstep_bits-1:0] amp_b_t;
  logic [current_bits-1:0]   cur_t;    // Truncated current
  logic [pwm_w-1:0]          scaled_a;
  logic [pwm_w-1:0]          scaled_b;
  logic [pwm_w-1:0]          dly_a_next;
  logic [pwm_w-1:0]          dly_b_next;

  // Phase A leads by a quarter turn, so it reads the cosine
  assign idx_a = phase_ct + phase_w'(quarter_ct);
  assign idx_b = phase_ct;  // Sine

  // Keep only the top bits of each operand
  assign amp_a_t = amp_a[amp_w-1 -: microstep_bits];
  assign amp_b_t = amp_b[amp_w-1 -: microstep_bits];
  assign cur_t   = coil_current[7 -: current_bits];

  // Product always fits in pwm_w bits
  assign scaled_a = {{current_bits{1'b0}}, amp_a_t} * {{microstep_bits{1'b0}}, cur_t};
  assign scaled_b = {{current_bits{1'b0}}, amp_b_t} * {{microstep_bits{1'b0}}, cur_t};

  // Centre alignment
  // The shorter pulse waits half the difference, the longer one starts at once
  always_comb begin
    dly_a_next = '0;
    dly_b_next = '0;
    if (scaled_a > scaled_b) begin
      dly_b_next = (scaled_a - scaled_b) >> 1;  // Rounds down
    end else begin
      dly_a_next = (scaled_b - scaled_a) >> 1;  // Zero when equal
    end
  end

  // Hold all four values for the whole period
  // The PWM loads them again at its next wrap
  always_ff @(posedge clk) begin
    if (resetn) begin
      val_a   <= '0;
      val_b   <= '0;
      delay_a <= '0;
      delay_b <= '0;
    end else if (period_start) begin
      val_a   <= scaled_a;
      val_b   <= scaled_b;
      delay_a <= dly_a_next;
      delay_b <= dly_b_next;
    end
  end

endmodule

/* source/stepper_svm_top.sv */
// Single clock; PWM period is 2**(microstep_bits+current_bits) cycles; resetn is active high
`timescale 1ns/1ps

module stepper_svm_top #(
  parameter int microstep_bits = 8,  // 1 to 8
  parameter int current_bits   = 4,  // 1 to 8
  localparam int pwm_w = microstep_bits + current_bits
) (
  input  logic       clk,
  input  logic       resetn,
  input  logic       step,     // One-cycle strobe
  input  logic       dir,
  input  logic       coil_en,
  input  logic [7:0] current,
  output logic       vref_a,   // Coil A voltage reference
  output logic       vref_b,   // Coil B voltage reference
  output logic       pwm_sync  // Period start, for ADC sampling
);

  import svm_pkg::*;

  logic [phase_w-1:0] phase_ct;
  logic [7:0]         coil_current;
  logic [phase_w-1:0] phase_a_idx;
  logic [phase_w-1:0] phase_b_idx;
  logic [amp_w-1:0]   amp_a;
  logic [amp_w-1:0]   amp_b;
  logic [pwm_w-1:0]   val_a;
  logic [pwm_w-1:0]   val_b;
  logic [pwm_w-1:0]   delay_a;
  logic [pwm_w-1:0]   delay_b;
  logic               period_start;

  assign pwm_sync = period_start;

  microstep_sequencer #(
    .microstep_bits(microstep_bits)
  ) u_seq (
    .clk, .resetn, .step, .dir, .coil_en, .current,
    .phase_ct, .coil_current
  );

  cos_lut u_lut (
    .clk, .idx_a(phase_a_idx), .idx_b(phase_b_idx), .amp_a, .amp_b
  );

  space_vector_modulator #(
    .microstep_bits(microstep_bits),
    .current_bits  (current_bits)
  ) u_svm (
    .clk, .resetn, .phase_ct, .coil_current, .period_start,
    .idx_a(phase_a_idx), .idx_b(phase_b_idx), .amp_a, .amp_b,
    .val_a, .val_b, .delay_a, .delay_b
  );

  // Both counters leave reset together, so phase A alone marks the period
  pwm_delayed #(.bits(pwm_w)) u_pwm_a (
    .clk, .resetn, .val(val_a), .delay(delay_a), .pwm(vref_a), .period_start(period_start)
  );

  pwm_delayed #(.bits(pwm_w)) u_pwm_b (
    .clk, .resetn, .val(val_b), .delay(delay_b), .pwm(vref_b), .period_start()
  );

endmodule

/* source/svm_pkg.sv */
// Widths are fixed at 8 bits because the cosine table file holds 8-bit entries for 256 angle steps
package svm_pkg;

  // Electrical angle, 256 steps per electrical turn
  parameter int phase_w = 8;

  // One cosine table entry
  // Entries are offset so 0x80 is zero current
  parameter int amp_w = 8;

  // Quarter-wave table depth
  // The other three quadrants come from symmetry
  parameter int quarter_ct = 64;

  // Hex table loaded at elaboration time
  // Must sit in the simulator or synthesis working directory
  parameter string cos_file = "cos_quarter.mem";

  // The quarter table must cover exactly two angle bits less than a full turn
  // Quadrant select uses the top two bits of the angle
  parameter int quad_bits = 2;

  // Full-scale amplitude, used when a quadrant is mirrored downward
  parameter int amp_max = (1 << amp_w) - 1;

endpackage
